//--- Bender.yml
package:
  name: fetch_frontend

sources:
  - include_dirs:
      - hw
    files:
      - hw/fetch_pkg.sv
      - hw/pc_gen.sv
      - hw/branch_predictor.sv
      - hw/imem_port.sv
      - hw/fetch_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - sim/fetch_assert.sv
      - sim/tb_fetch_top.sv

//--- fetch_frontend.f
+incdir+hw
hw/fetch_pkg.sv
hw/pc_gen.sv
hw/branch_predictor.sv
hw/imem_port.sv
hw/fetch_top.sv
sim/fetch_assert.sv
sim/tb_fetch_top.sv

//--- hw/branch_predictor.sv
`timescale 1ns/1ns
`include "fetch_defs.svh"

module branch_predictor (
    input  logic               clk_i,
    input  logic               rstn_i,
    input  logic [`ADDR_W-1:0] lookup_pc_i,
    // Resolved branch from execute
    input  logic               upd_valid_i,
    input  logic [`ADDR_W-1:0] upd_pc_i,
    input  logic               upd_taken_i,
    input  logic [`ADDR_W-1:0] upd_target_i,
    output logic               hit_o,
    output logic               taken_o,
    output logic [`ADDR_W-1:0] target_o
);

    localparam int ENTRIES = 1 << `BP_IDX_W;
    localparam int TAG_W   = `ADDR_W - `BP_IDX_W - 2;

    logic [ENTRIES-1:0] valid_q;
    logic [1:0]         cnt_q    [ENTRIES];
    logic [TAG_W-1:0]   tag_q    [ENTRIES];
    logic [`ADDR_W-1:0] target_q [ENTRIES];

    logic [`BP_IDX_W-1:0] rd_idx;
    logic [TAG_W-1:0]     rd_tag;
    logic [`BP_IDX_W-1:0] upd_idx;
    logic [TAG_W-1:0]     upd_tag;
    logic                 upd_hit;
    logic [1:0]           cnt_d;

    // Lookup, purely combinational on the fetch pc
    assign rd_idx   = lookup_pc_i[`BP_IDX_W+1:2];
    assign rd_tag   = lookup_pc_i[`ADDR_W-1:`BP_IDX_W+2];
    assign hit_o    = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
    // Weakly or strongly taken
    assign taken_o  = cnt_q[rd_idx][1];
    assign target_o = target_q[rd_idx];

    assign upd_idx = upd_pc_i[`BP_IDX_W+1:2];
    assign upd_tag = upd_pc_i[`ADDR_W-1:`BP_IDX_W+2];
    assign upd_hit = valid_q[upd_idx] && (tag_q[upd_idx] == upd_tag);

    // New counter value for the updated entry
    always_comb begin
        if (!upd_hit) begin
            // Fresh entry starts weak in the resolved direction
            cnt_d = upd_taken_i ? 2'd2 : 2'd1;
        end else if (upd_taken_i) begin
            cnt_d = (cnt_q[upd_idx] == 2'd3) ? 2'd3 : cnt_q[upd_idx] + 2'd1;
        end else begin
            cnt_d = (cnt_q[upd_idx] == 2'd0) ? 2'd0 : cnt_q[upd_idx] - 2'd1;
        end
    end

    // Valid bits and counters
    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            valid_q <= '0;
            for (int i = 0; i < ENTRIES; i++) begin
                cnt_q[i] <= 2'd1;
            end
        end else if (upd_valid_i) begin
            valid_q[upd_idx] <= 1'b1;
            cnt_q[upd_idx]   <= cnt_d;
        end
    end

    // Tag and target, rewritten on a miss, target refreshed on a taken hit
    always_ff @(posedge clk_i) begin
        if (upd_valid_i && (!upd_hit || upd_taken_i)) begin
            tag_q[upd_idx]    <= upd_tag;
            target_q[upd_idx] <= upd_target_i;
        end
    end

endmodule

//--- hw/fetch_defs.svh
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// Width of every fetch address in the front end
`define ADDR_W 32

// First fetch address after reset
`define RESET_PC 32'h0000_1000

// Predictor index width, 16 direct-mapped entries
// Index from pc[5:2], tag from pc[31:6]
`define BP_IDX_W 4

`endif

//--- hw/fetch_pkg.sv
package fetch_pkg;

    // Exception causes raised by the fetch stage
    typedef enum logic [3:0] {
        CAUSE_MISALIGNED   = 4'd0,
        CAUSE_ACCESS_FAULT = 4'd1
    } ex_cause_e;

    // Direction predicted for a fetched pc
    typedef enum logic {
        PRED_NOT_TAKEN = 1'b0,
        PRED_TAKEN     = 1'b1
    } bp_decision_e;

    // One word toward decode
    // Instruction view when fetch_ex_o is low, exception record otherwise
    typedef union packed {
        logic [31:0] instr;
        struct packed {
            ex_cause_e   cause;
            // Always zero in an exception record
            logic [27:0] zero;
        } ex;
    } fetch_word_u;

endpackage

//--- hw/fetch_top.sv
`timescale 1ns/1ns
`include "fetch_defs.svh"

module fetch_top import fetch_pkg::*; (
    input  logic               clk_i,
    input  logic               rstn_i,
    // Redirect from the back end
    input  logic               redirect_valid_i,
    input  logic [`ADDR_W-1:0] redirect_pc_i,
    // Predictor training from execute
    input  logic               upd_valid_i,
    input  logic [`ADDR_W-1:0] upd_pc_i,
    input  logic               upd_taken_i,
    input  logic [`ADDR_W-1:0] upd_target_i,
    input  logic               stall_i,
    // Instruction memory, four-phase
    output logic               mem_req_o,
    output logic [`ADDR_W-1:0] mem_addr_o,
    input  logic               mem_ack_i,
    input  logic [31:0]        mem_rdata_i,
    input  logic               mem_err_i,
    // Toward decode
    output logic               fetch_valid_o,
    output logic [`ADDR_W-1:0] fetch_pc_o,
    output fetch_word_u        fetch_word_o,
    output logic               fetch_ex_o,
    output bp_decision_e       fetch_pred_o,
    output logic [`ADDR_W-1:0] fetch_pred_addr_o
);

    logic [`ADDR_W-1:0] pc;
    logic               pc_misaligned;
    bp_decision_e       pred;
    logic [`ADDR_W-1:0] pred_addr;
    logic               take;
    logic               bp_hit;
    logic               bp_taken;
    logic [`ADDR_W-1:0] bp_target;

    pc_gen i_pc_gen (
        .clk_i            (clk_i),
        .rstn_i           (rstn_i),
        .take_i           (take),
        .redirect_valid_i (redirect_valid_i),
        .redirect_pc_i    (redirect_pc_i),
        .bp_taken_i       (bp_taken),
        .bp_hit_i         (bp_hit),
        .bp_target_i      (bp_target),
        .pc_o             (pc),
        .pc_misaligned_o  (pc_misaligned),
        .pred_o           (pred),
        .pred_addr_o      (pred_addr)
    );

    // Looked up with the pc being fetched
    branch_predictor i_bp (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .lookup_pc_i  (pc),
        .upd_valid_i  (upd_valid_i),
        .upd_pc_i     (upd_pc_i),
        .upd_taken_i  (upd_taken_i),
        .upd_target_i (upd_target_i),
        .hit_o        (bp_hit),
        .taken_o      (bp_taken),
        .target_o     (bp_target)
    );

    imem_port i_port (
        .clk_i             (clk_i),
        .rstn_i            (rstn_i),
        .pc_i              (pc),
        .pc_misaligned_i   (pc_misaligned),
        .pred_i            (pred),
        .pred_addr_i       (pred_addr),
        .redirect_valid_i  (redirect_valid_i),
        .stall_i           (stall_i),
        .mem_ack_i         (mem_ack_i),
        .mem_rdata_i       (mem_rdata_i),
        .mem_err_i         (mem_err_i),
        .take_o            (take),
        .mem_req_o         (mem_req_o),
        .mem_addr_o        (mem_addr_o),
        .fetch_valid_o     (fetch_valid_o),
        .fetch_pc_o        (fetch_pc_o),
        .fetch_word_o      (fetch_word_o),
        .fetch_ex_o        (fetch_ex_o),
        .fetch_pred_o      (fetch_pred_o),
        .fetch_pred_addr_o (fetch_pred_addr_o)
    );

endmodule

//--- hw/imem_port.sv
`timescale 1ns/1ns
`include "fetch_defs.svh"

module imem_port import fetch_pkg::*; (
    input  logic               clk_i,
    input  logic               rstn_i,
    input  logic [`ADDR_W-1:0] pc_i,
    input  logic               pc_misaligned_i,
    input  bp_decision_e       pred_i,
    input  logic [`ADDR_W-1:0] pred_addr_i,
    input  logic               redirect_valid_i,
    input  logic               stall_i,
    input  logic               mem_ack_i,
    input  logic [31:0]        mem_rdata_i,
    input  logic               mem_err_i,
    output logic               take_o,
    output logic               mem_req_o,
    output logic [`ADDR_W-1:0] mem_addr_o,
    output logic               fetch_valid_o,
    output logic [`ADDR_W-1:0] fetch_pc_o,
    output fetch_word_u        fetch_word_o,
    output logic               fetch_ex_o,
    output bp_decision_e       fetch_pred_o,
    output logic [`ADDR_W-1:0] fetch_pred_addr_o
);

    // Handshake states
    localparam logic [1:0] ST_IDLE     = 2'd0;
    localparam logic [1:0] ST_REQ      = 2'd1;
    localparam logic [1:0] ST_WAIT_LOW = 2'd2;
    localparam logic [1:0] ST_MISAL    = 2'd3;

    logic [1:0] state_q;
    logic [1:0] state_d;
    logic       kill_q;

    // Accepted pc and its prediction
    logic [`ADDR_W-1:0] req_pc_q;
    bp_decision_e       req_pred_q;
    logic [`ADDR_W-1:0] req_pred_addr_q;

    // Result of the current access
    logic               res_valid;
    fetch_word_u        res_word;
    logic               res_ex;

    // Spare slot, filled when the output is stalled
    logic               rsp_valid_q;
    logic [`ADDR_W-1:0] rsp_pc_q;
    fetch_word_u        rsp_word_q;
    logic               rsp_ex_q;
    bp_decision_e       rsp_pred_q;
    logic [`ADDR_W-1:0] rsp_pred_addr_q;

    // Output register toward decode
    logic               out_valid_q;
    logic [`ADDR_W-1:0] out_pc_q;
    fetch_word_u        out_word_q;
    logic               out_ex_q;
    bp_decision_e       out_pred_q;
    logic [`ADDR_W-1:0] out_pred_addr_q;

    logic out_free;
    logic out_load;
    logic rsp_load;

    // Accept a pc only with the spare slot empty
    // so a result always has a place to land
    assign take_o = (state_q == ST_IDLE) && !rsp_valid_q && !redirect_valid_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (take_o) begin
                    // Misaligned pc never reaches memory
                    state_d = pc_misaligned_i ? ST_MISAL : ST_REQ;
                end
            end
            ST_REQ: begin
                if (mem_ack_i) begin
                    state_d = ST_WAIT_LOW;
                end
            end
            ST_WAIT_LOW: begin
                // Return to zero before the next request
                if (!mem_ack_i) begin
                    state_d = ST_IDLE;
                end
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            state_q <= ST_IDLE;
            kill_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            // Overtaken request, kept until its ack arrives
            kill_q  <= (state_q == ST_REQ) && !mem_ack_i && (kill_q || redirect_valid_i);
        end
    end

    always_ff @(posedge clk_i) begin
        if (take_o) begin
            req_pc_q        <= pc_i;
            req_pred_q      <= pred_i;
            req_pred_addr_q <= pred_addr_i;
        end
    end

    assign mem_req_o  = (state_q == ST_REQ);
    assign mem_addr_o = req_pc_q;

    // Killed or redirected results are dropped here
    assign res_valid = !redirect_valid_i &&
                       (((state_q == ST_REQ) && mem_ack_i && !kill_q) ||
                        (state_q == ST_MISAL));

    // Misalignment first, then access fault
    always_comb begin
        res_word = '0;
        res_ex   = 1'b1;
        if (state_q == ST_MISAL) begin
            res_word.ex.cause = CAUSE_MISALIGNED;
        end else if (mem_err_i) begin
            res_word.ex.cause = CAUSE_ACCESS_FAULT;
        end else begin
            res_word.instr = mem_rdata_i;
            res_ex         = 1'b0;
        end
    end

    // Output empty or being consumed this cycle
    assign out_free = !out_valid_q || !stall_i;
    assign out_load = out_free && (rsp_valid_q || res_valid);
    assign rsp_load = !out_free && res_valid;

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            out_valid_q <= 1'b0;
            rsp_valid_q <= 1'b0;
        end else if (redirect_valid_i) begin
            // Flush both slots
            out_valid_q <= 1'b0;
            rsp_valid_q <= 1'b0;
        end else begin
            if (out_free) begin
                out_valid_q <= rsp_valid_q || res_valid;
                rsp_valid_q <= 1'b0;
            end else if (rsp_load) begin
                rsp_valid_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rsp_load) begin
            rsp_pc_q        <= req_pc_q;
            rsp_word_q      <= res_word;
            rsp_ex_q        <= res_ex;
            rsp_pred_q      <= req_pred_q;
            rsp_pred_addr_q <= req_pred_addr_q;
        end
        if (out_load) begin
            // Spare slot is older, it drains first
            if (rsp_valid_q) begin
                out_pc_q        <= rsp_pc_q;
                out_word_q      <= rsp_word_q;
                out_ex_q        <= rsp_ex_q;
                out_pred_q      <= rsp_pred_q;
                out_pred_addr_q <= rsp_pred_addr_q;
            end else begin
                out_pc_q        <= req_pc_q;
                out_word_q      <= res_word;
                out_ex_q        <= res_ex;
                out_pred_q      <= req_pred_q;
                out_pred_addr_q <= req_pred_addr_q;
            end
        end
    end

    assign fetch_valid_o     = out_valid_q;
    assign fetch_pc_o        = out_pc_q;
    assign fetch_word_o      = out_word_q;
    assign fetch_ex_o        = out_ex_q;
    assign fetch_pred_o      = out_pred_q;
    assign fetch_pred_addr_o = out_pred_addr_q;

endmodule

//--- hw/pc_gen.sv
`timescale 1ns/1ns
`include "fetch_defs.svh"

module pc_gen import fetch_pkg::*; (
    input  logic               clk_i,
    input  logic               rstn_i,
    // Current pc accepted by the memory port
    input  logic               take_i,
    input  logic               redirect_valid_i,
    input  logic [`ADDR_W-1:0] redirect_pc_i,
    // Lookup result for pc_o
    input  logic               bp_taken_i,
    input  logic               bp_hit_i,
    input  logic [`ADDR_W-1:0] bp_target_i,
    output logic [`ADDR_W-1:0] pc_o,
    output logic               pc_misaligned_o,
    output bp_decision_e       pred_o,
    output logic [`ADDR_W-1:0] pred_addr_o
);

    logic [`ADDR_W-1:0] pc_q;
    logic [`ADDR_W-1:0] pc_d;
    logic [`ADDR_W-1:0] seq_pc;
    logic [`ADDR_W-1:0] pred_pc;
    logic               pred_taken;

    // Sequential successor
    assign seq_pc = pc_q + 'd4;

    // Only a valid entry that says taken redirects fetch
    assign pred_taken = bp_hit_i && bp_taken_i;
    assign pred_pc    = pred_taken ? bp_target_i : seq_pc;

    // Next pc select
    always_comb begin
        pc_d = pc_q;
        // Redirect wins even without take, the old pc is dropped
        if (redirect_valid_i) begin
            pc_d = redirect_pc_i;
        end else if (take_i) begin
            pc_d = pred_pc;
        end
    end

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            pc_q <= `RESET_PC;
        end else begin
            pc_q <= pc_d;
        end
    end

    assign pc_o = pc_q;

    // Word alignment check, no compressed support
    assign pc_misaligned_o = |pc_q[1:0];

    // Prediction travels with this pc down to decode
    // pred_addr_o is where fetch goes next without a redirect
    assign pred_o      = pred_taken ? PRED_TAKEN : PRED_NOT_TAKEN;
    assign pred_addr_o = pred_pc;

endmodule

//--- sim/fetch_assert.sv
`timescale 1ns/1ns
`include "fetch_defs.svh"

module fetch_assert import fetch_pkg::*; (
    input logic               clk_i,
    input logic               rstn_i,
    input logic               redirect_valid_i,
    input logic               stall_i,
    input logic               mem_req_o,
    input logic [`ADDR_W-1:0] mem_addr_o,
    input logic               mem_ack_i,
    input logic               fetch_valid_o,
    input logic [`ADDR_W-1:0] fetch_pc_o,
    input fetch_word_u        fetch_word_o
);

    // Number of assertion failures so far
    int fail_cnt = 0;

    // Request stays up until the memory answers
    req_held: assert property (@(posedge clk_i) disable iff (!rstn_i)
        mem_req_o && !mem_ack_i |=> mem_req_o)
        else begin
            $error("req dropped before ack");
            fail_cnt++;
        end

    // Address frozen for the whole request
    addr_stable: assert property (@(posedge clk_i) disable iff (!rstn_i)
        mem_req_o && !mem_ack_i |=> $stable(mem_addr_o))
        else begin
            $error("address changed during request");
            fail_cnt++;
        end

    // Return to zero before the next request
    req_after_ack_low: assert property (@(posedge clk_i) disable iff (!rstn_i)
        $rose(mem_req_o) |-> !mem_ack_i)
        else begin
            $error("req raised while ack high");
            fail_cnt++;
        end

    // Stalled word stays put
    out_hold: assert property (@(posedge clk_i) disable iff (!rstn_i)
        fetch_valid_o && stall_i && !redirect_valid_i |=>
        fetch_valid_o && $stable(fetch_pc_o) && $stable(fetch_word_o))
        else begin
            $error("output changed under stall");
            fail_cnt++;
        end

    // Output register flushed by a redirect
    flush_on_redirect: assert property (@(posedge clk_i) disable iff (!rstn_i)
        redirect_valid_i |=> !fetch_valid_o)
        else begin
            $error("valid output after redirect");
            fail_cnt++;
        end

endmodule

bind imem_port fetch_assert i_fetch_assert (
    .clk_i            (clk_i),
    .rstn_i           (rstn_i),
    .redirect_valid_i (redirect_valid_i),
    .stall_i          (stall_i),
    .mem_req_o        (mem_req_o),
    .mem_addr_o       (mem_addr_o),
    .mem_ack_i        (mem_ack_i),
    .fetch_valid_o    (fetch_valid_o),
    .fetch_pc_o       (fetch_pc_o),
    .fetch_word_o     (fetch_word_o)
);

//--- sim/tb_fetch_top.sv
`timescale 1ns/1ns
`include "fetch_defs.svh"

module tb_fetch_top import fetch_pkg::*; ();

    // Stimulus budget per test with test 1 counted as 100
    localparam int TOTAL_CYCLES = 100 + 300 + 400 + 300 + 60 + 200;

    logic               clk_i;
    logic               rstn_i;
    logic               redirect_valid_i;
    logic [`ADDR_W-1:0] redirect_pc_i;
    logic               upd_valid_i;
    logic [`ADDR_W-1:0] upd_pc_i;
    logic               upd_taken_i;
    logic [`ADDR_W-1:0] upd_target_i;
    logic               stall_i;
    logic               mem_req_o;
    logic [`ADDR_W-1:0] mem_addr_o;
    logic               mem_ack_i;
    logic [31:0]        mem_rdata_i;
    logic               mem_err_i;
    logic               fetch_valid_o;
    logic [`ADDR_W-1:0] fetch_pc_o;
    fetch_word_u        fetch_word_o;
    logic               fetch_ex_o;
    bp_decision_e       fetch_pred_o;
    logic [`ADDR_W-1:0] fetch_pred_addr_o;

    // Predictor mirror and expected next pc
    logic               m_valid  [16];
    logic [1:0]         m_cnt    [16];
    logic [25:0]        m_tag    [16];
    logic [31:0]        m_target [16];
    logic [31:0]        model_pc;

    int          errors;
    int          words;
    int          taken_words;
    int          misal_words;
    int          fault_words;
    logic [31:0] rnd;
    logic [31:0] rsp_rnd;
    logic [1:0]  rsp_delay;

    fetch_top i_dut (.*);

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // Counter and entry rules of the predictor
    task automatic train_model(input logic [31:0] pc, input logic tk, input logic [31:0] tgt);
        int  idx;
        logic hit;
        idx = pc[5:2];
        hit = m_valid[idx] && (m_tag[idx] == pc[31:6]);
        if (!hit) begin
            m_cnt[idx] = tk ? 2'd2 : 2'd1;
            m_tag[idx] = pc[31:6];
            m_target[idx] = tgt;
        end else if (tk) begin
            m_cnt[idx] = (m_cnt[idx] == 2'd3) ? 2'd3 : m_cnt[idx] + 2'd1;
            m_target[idx] = tgt;
        end else begin
            m_cnt[idx] = (m_cnt[idx] == 2'd0) ? 2'd0 : m_cnt[idx] - 2'd1;
        end
        m_valid[idx] = 1'b1;
    endtask

    // Compare one consumed word with the model, then advance
    task automatic check_word();
        int          idx;
        logic        ptaken;
        logic [31:0] next_pc;
        logic [31:0] exp_word;
        logic        exp_ex;
        idx = model_pc[5:2];
        ptaken = m_valid[idx] && (m_tag[idx] == model_pc[31:6]) && m_cnt[idx] >= 2'd2;
        next_pc = ptaken ? m_target[idx] : model_pc + 32'd4;
        exp_ex = 1'b1;
        if (model_pc[1:0] != 2'b00) begin
            exp_word = {CAUSE_MISALIGNED, 28'd0};
            misal_words++;
        end else if (model_pc >= 32'h0000_3000 && model_pc <= 32'h0000_3fff) begin
            exp_word = {CAUSE_ACCESS_FAULT, 28'd0};
            fault_words++;
        end else begin
            exp_word = model_pc ^ 32'h5a5a_0000;
            exp_ex = 1'b0;
        end
        check("fetch_pc_o", fetch_pc_o, model_pc);
        check("fetch_ex_o", fetch_ex_o, exp_ex);
        check("fetch_word_o", fetch_word_o, exp_word);
        check("fetch_pred_o", fetch_pred_o, ptaken);
        check("fetch_pred_addr_o", fetch_pred_addr_o, next_pc);
        if (ptaken) taken_words++;
        words++;
        model_pc = next_pc;
    endtask

    // Samples the values of the cycle just ended
    always @(posedge clk_i) begin
        if (rstn_i) begin
            if (mem_req_o && mem_addr_o[1:0] != 2'b00) begin
                errors++;
                $display("Memory request made for misaligned address %h", mem_addr_o);
            end
            if (redirect_valid_i) begin
                if (upd_valid_i) train_model(upd_pc_i, upd_taken_i, upd_target_i);
                model_pc = redirect_pc_i;
            end else if (fetch_valid_o && !stall_i) begin
                check_word();
            end
        end
    end

    // Memory responder with a random ack delay of 0 to 3 cycles
    always @(posedge clk_i) begin
        if (mem_req_o && !mem_ack_i) begin
            if (rsp_delay == 2'd0) begin
                mem_ack_i   <= 1'b1;
                mem_rdata_i <= mem_addr_o ^ 32'h5a5a_0000;
                mem_err_i   <= (mem_addr_o >= 32'h0000_3000) && (mem_addr_o <= 32'h0000_3fff);
                rsp_rnd = xorshift(rsp_rnd);
                rsp_delay <= rsp_rnd[1:0];
            end else begin
                rsp_delay <= rsp_delay - 2'd1;
            end
        end else if (mem_ack_i && !mem_req_o) begin
            mem_ack_i <= 1'b0;
        end
    end

    task automatic drive_cycle(input logic st, input logic rd, input logic [31:0] rpc,
                               input logic up, input logic [31:0] upc, input logic utk,
                               input logic [31:0] utgt);
        @(posedge clk_i);
        stall_i          <= st;
        redirect_valid_i <= rd;
        redirect_pc_i    <= rpc;
        upd_valid_i      <= up;
        upd_pc_i         <= upc;
        upd_taken_i      <= utk;
        upd_target_i     <= utgt;
    endtask

    task automatic report(input string name, input int err0, input int w0);
        $display("%s: words=%0d errors=%0d", name, words - w0, errors - err0);
    endtask

    // Timeout
    initial begin
        #((TOTAL_CYCLES * 8 + 1000) * 4);
        $display("Timeout, fetch front end stopped delivering words");
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        int e0;
        int w0;
        int c;
        errors = 0;
        words = 0;
        taken_words = 0;
        misal_words = 0;
        fault_words = 0;
        rnd = 32'ha2a6;
        rsp_rnd = 32'ha2a6;
        rsp_delay = 2'd0;
        model_pc = `RESET_PC;
        for (int i = 0; i < 16; i++) begin
            m_valid[i] = 1'b0;
            m_cnt[i] = 2'd1;
        end
        rstn_i = 1'b0;
        redirect_valid_i = 1'b0;
        redirect_pc_i = '0;
        upd_valid_i = 1'b0;
        upd_pc_i = '0;
        upd_taken_i = 1'b0;
        upd_target_i = '0;
        stall_i = 1'b0;
        mem_ack_i = 1'b0;
        mem_rdata_i = '0;
        mem_err_i = 1'b0;
        repeat (5) @(posedge clk_i);
        rstn_i <= 1'b1;

        // Sequential fetch from the reset pc
        e0 = errors;
        w0 = words;
        while (words < 20) drive_cycle(0, 0, 0, 0, 0, 0, 0);
        // Monitor handles the last edge before the counts are read
        @(negedge clk_i);
        report("test 1 sequential", e0, w0);

        // Random back-pressure
        e0 = errors;
        w0 = words;
        for (c = 0; c < 300; c++) begin
            rnd = xorshift(rnd);
            drive_cycle(rnd[0], 0, 0, 0, 0, 0, 0);
        end
        @(negedge clk_i);
        report("test 2 random stall", e0, w0);

        // Redirects at random times with targets below the fault range
        e0 = errors;
        w0 = words;
        for (c = 0; c < 400; c++) begin
            rnd = xorshift(rnd);
            drive_cycle(rnd[1:0] == 2'b00, rnd[7:4] == 4'h0,
                        32'h0000_1000 + {rnd[20:10], 2'b00}, 0, 0, 0, 0);
        end
        @(negedge clk_i);
        report("test 3 redirects", e0, w0);

        // Training comes with a redirect so no take sees a half-written table
        e0 = errors;
        w0 = words;
        for (c = 0; c < 300; c++) begin
            rnd = xorshift(rnd);
            if (rnd[4:0] < 5'd2) begin
                drive_cycle(0, 1, 32'h0000_2000 + {rnd[9:6], 2'b00}, 1,
                            32'h0000_2000 + {rnd[13:10], 2'b00}, rnd[14] | rnd[15],
                            32'h0000_2000 + {rnd[20:16], 2'b00});
            end else begin
                drive_cycle(rnd[21] & rnd[22], 0, 0, 0, 0, 0, 0);
            end
        end
        @(negedge clk_i);
        if (taken_words == 0) begin
            errors++;
            $display("No word with a taken prediction was delivered");
        end
        report("test 4 predictor", e0, w0);

        // Misaligned redirect
        e0 = errors;
        w0 = words;
        drive_cycle(0, 1, 32'h0000_1002, 0, 0, 0, 0);
        for (c = 0; c < 59; c++) drive_cycle(0, 0, 0, 0, 0, 0, 0);
        @(negedge clk_i);
        if (misal_words == 0) begin
            errors++;
            $display("No misaligned exception word was delivered");
        end
        report("test 5 misaligned", e0, w0);

        // Fetch through the access fault range
        e0 = errors;
        w0 = words;
        drive_cycle(0, 1, 32'h0000_3fe0, 0, 0, 0, 0);
        for (c = 0; c < 199; c++) begin
            rnd = xorshift(rnd);
            drive_cycle(rnd[2:0] == 3'b000, 0, 0, 0, 0, 0, 0);
        end
        @(negedge clk_i);
        if (fault_words == 0) begin
            errors++;
            $display("No access fault word was delivered");
        end
        report("test 6 access fault", e0, w0);

        // Handshake and output hold assertions bound to the memory port
        if (i_dut.i_port.i_fetch_assert.fail_cnt != 0) begin
            errors++;
            $display("Bound assertions failed %0d times", i_dut.i_port.i_fetch_assert.fail_cnt);
        end

        $display("total words=%0d errors=%0d", words, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
